// File: flist.f
+incdir+.
obi_pkg.sv
mem_map_pkg.sv
obi_addr_demux.sv
obi_txn_fifo.sv
obi_sram_bank.sv
obi_err_sbr.sv
obi_rsp_mux.sv
obi_mem_domain.sv
tb_obi_mem_domain.sv

// File: run.sh
#!/bin/sh
# Build and run the memory domain testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f \
    --top-module tb_obi_mem_domain -o tb_obi_mem_domain; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_obi_mem_domain)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// File: tb_obi_mem_domain.sv
// ------------------------------
// Testbench for the OBI memory domain
// Directed tests against a reference model of both banks
// ------------------------------
`include "mem_domain_params.svh"

module tb_obi_mem_domain;

  localparam int unsigned BANK_BYTES = `SRAM_BANK_WORDS * 4;
  localparam int unsigned BANK_AW    = $clog2(`NUM_SRAM_BANKS);
  localparam int unsigned WORD_AW    = $clog2(`SRAM_BANK_WORDS);
  localparam int unsigned NUM_FILL   = `NUM_SRAM_BANKS * `SRAM_BANK_WORDS;
  localparam int unsigned NUM_MIXED  = 1000;
  // Roughly three times the 1600 cycles of the fill and mixed bursts
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic              clk;
  logic              rst;
  obi_pkg::obi_req_t obi_req;
  obi_pkg::obi_rsp_t obi_rsp;

  int unsigned cycle_cnt = 0;
  logic [31:0] lcg_state = 32'h2e0f739b;

  // Reference contents of both banks
  obi_pkg::data_t ref_mem [`NUM_SRAM_BANKS][`SRAM_BANK_WORDS];

  // Requests still to issue and responses still owed
  obi_pkg::obi_a_chan_t burst_q [$];
  obi_pkg::data_t       exp_data_q [$];
  logic                 exp_err_q [$];
  int unsigned          due_q [$];

  obi_mem_domain u_dut (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .obi_req_i ( obi_req ),
    .obi_rsp_o ( obi_rsp )
  );

  always #50 clk = ~clk;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped at cycle %0d", cycle_cnt);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_data(input obi_pkg::data_t exp_val, input obi_pkg::data_t act_val,
                              input string name);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: rdata expected %08h, actual %08h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic compare_err(input logic exp_val, input logic act_val, input string name);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: err expected %b, actual %b", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // Expected response from the address map
  // Writes also update the model
  task automatic predict(input obi_pkg::obi_a_chan_t a, output obi_pkg::data_t exp_data,
                         output logic exp_err);
    obi_pkg::addr_t     off;
    logic [BANK_AW-1:0] bank;
    logic [WORD_AW-1:0] word;
    off  = a.addr - `SRAM_BASE_ADDR;
    bank = off[WORD_AW+2 +: BANK_AW];
    word = off[WORD_AW+1:2];
    if ((a.addr < `SRAM_BASE_ADDR) || (off >= `NUM_SRAM_BANKS * BANK_BYTES)) begin
      exp_data = `ERR_RSP_DATA;
      exp_err  = 1'b1;
    end else if (a.we) begin
      for (int b = 0; b < 4; b++) begin
        if (a.be[b]) begin
          ref_mem[bank][word][8*b +: 8] = a.wdata[8*b +: 8];
        end
      end
      exp_data = '0;
      exp_err  = 1'b0;
    end else begin
      exp_data = ref_mem[bank][word];
      exp_err  = 1'b0;
    end
  endtask

  task automatic queue_write(input obi_pkg::addr_t addr, input obi_pkg::be_t be,
                             input obi_pkg::data_t wdata);
    obi_pkg::obi_a_chan_t a;
    a.addr  = addr;
    a.we    = 1'b1;
    a.be    = be;
    a.wdata = wdata;
    burst_q.push_back(a);
  endtask

  task automatic queue_read(input obi_pkg::addr_t addr);
    obi_pkg::obi_a_chan_t a;
    a.addr  = addr;
    a.we    = 1'b0;
    a.be    = 4'hF;
    a.wdata = '0;
    burst_q.push_back(a);
  endtask

  // Checks the response owed in this cycle, or that none arrives
  task automatic check_response(input string name);
    obi_pkg::data_t exp_data;
    logic           exp_err;
    if ((due_q.size() > 0) && (due_q[0] == cycle_cnt)) begin
      if (obi_rsp.rvalid !== 1'b1) begin
        $display("%s: no rvalid %0d cycles after the grant", name, `RSP_LATENCY);
        abort_run();
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_err  = exp_err_q.pop_front();
        void'(due_q.pop_front());
        compare_data(exp_data, obi_rsp.r.rdata, name);
        compare_err(exp_err, obi_rsp.r.err, name);
      end
    end else if (obi_rsp.rvalid !== 1'b0) begin
      $display("%s: rvalid seen with no response owed in this cycle", name);
      abort_run();
    end
  endtask

  // Issues the queued requests one per cycle and checks every response
  task automatic run_burst(input string name);
    obi_pkg::data_t exp_data;
    logic           exp_err;
    int unsigned    idx;
    idx = 0;
    while ((idx < burst_q.size()) || (due_q.size() > 0)) begin
      @(posedge clk);
      if (idx < burst_q.size()) begin
        obi_req.req <= 1'b1;
        obi_req.a   <= burst_q[idx];
      end else begin
        obi_req.req <= 1'b0;
      end
      @(negedge clk);
      check_response(name);
      if (obi_req.req && obi_rsp.gnt) begin
        predict(burst_q[idx], exp_data, exp_err);
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        due_q.push_back(cycle_cnt + `RSP_LATENCY);
        idx++;
      end
    end
    burst_q.delete();
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic idle_after_reset();
    @(negedge clk);
    if (obi_rsp.rvalid !== 1'b0) begin
      $display("[ERROR] reset_idle: rvalid expected 0, actual %b", obi_rsp.rvalid);
      abort_run();
    end else if (obi_rsp.gnt !== 1'b1) begin
      $display("[ERROR] reset_idle: gnt expected 1, actual %b", obi_rsp.gnt);
      abort_run();
    end
  endtask

  task automatic write_read_back();
    queue_write(`SRAM_BASE_ADDR + 4 * 5, 4'hF, lcg_next());
    queue_write(`SRAM_BASE_ADDR + BANK_BYTES + 4 * 200, 4'hF, lcg_next());
    queue_read(`SRAM_BASE_ADDR + 4 * 5);
    queue_read(`SRAM_BASE_ADDR + BANK_BYTES + 4 * 200);
    run_burst("write_read");
  endtask

  task automatic byte_enable_merge();
    queue_write(`SRAM_BASE_ADDR + BANK_BYTES + 4 * 17, 4'hF, lcg_next());
    queue_write(`SRAM_BASE_ADDR + BANK_BYTES + 4 * 17, 4'b0101, lcg_next());
    queue_read(`SRAM_BASE_ADDR + BANK_BYTES + 4 * 17);
    queue_write(`SRAM_BASE_ADDR + 4 * 255, 4'hF, lcg_next());
    queue_write(`SRAM_BASE_ADDR + 4 * 255, 4'b1000, lcg_next());
    queue_read(`SRAM_BASE_ADDR + 4 * 255);
    run_burst("byte_enables");
  endtask

  task automatic unmapped_access();
    queue_write(`SRAM_BASE_ADDR, 4'hF, lcg_next());
    // Just past bank 1 with the low bits of bank 0 word 0
    queue_write(`SRAM_BASE_ADDR + 2 * BANK_BYTES, 4'hF, lcg_next());
    queue_write(`SRAM_BASE_ADDR - 4, 4'hF, lcg_next());
    queue_read(32'h8000_0010);
    queue_read(`SRAM_BASE_ADDR);
    queue_read(`SRAM_BASE_ADDR + 4 * 5);
    run_burst("unmapped");
  endtask

  task automatic pipelined_order();
    logic [31:0]    rnd;
    obi_pkg::addr_t addr;
    for (int unsigned i = 0; i < NUM_FILL; i++) begin
      queue_write(`SRAM_BASE_ADDR + 4 * i, 4'hF, lcg_next());
    end
    run_burst("pipeline_fill");
    // Targets rotate bank 0, bank 1, error
    for (int unsigned i = 0; i < NUM_MIXED; i++) begin
      rnd = lcg_next();
      case (i % 3)
        0:       addr = `SRAM_BASE_ADDR + {22'd0, rnd[23:16], 2'b00};
        1:       addr = `SRAM_BASE_ADDR + BANK_BYTES + {22'd0, rnd[23:16], 2'b00};
        default: addr = {4'h2, rnd[27:0]};
      endcase
      if (rnd[31]) begin
        queue_write(addr, rnd[27:24], lcg_next());
      end else begin
        queue_read(addr);
      end
    end
    run_burst("pipeline_order");
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    obi_req = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    idle_after_reset();
    write_read_back();
    byte_enable_merge();
    unmapped_access();
    pipelined_order();
    $display("test passed");
    $finish;
  end

endmodule

// File: obi_mem_domain.sv
// ------------------------------
// OBI memory domain
// Two SRAM banks and an error target behind one port
// ------------------------------
`include "mem_domain_params.svh"

module obi_mem_domain (
  input  logic              clk_i,
  input  logic              rst_i,
  input  obi_pkg::obi_req_t obi_req_i,
  output obi_pkg::obi_rsp_t obi_rsp_o
);

  obi_pkg::obi_req_t [`NUM_TARGETS-1:0] tgt_req;
  obi_pkg::obi_rsp_t [`NUM_TARGETS-1:0] tgt_rsp;
  obi_pkg::obi_rsp_t                    mux_rsp;

  logic                 gnt;
  logic                 push;
  logic                 pop;
  logic                 fifo_full;
  logic                 fifo_empty;
  mem_map_pkg::target_e push_tgt;
  mem_map_pkg::target_e head_tgt;

  // ----------------------------
  // Request side
  // ----------------------------
  obi_addr_demux i_addr_demux (
    .obi_req_i   ( obi_req_i ),
    .gnt_o       ( gnt       ),
    .tgt_req_o   ( tgt_req   ),
    .push_o      ( push      ),
    .push_tgt_o  ( push_tgt  ),
    .fifo_full_i ( fifo_full ),
    .pop_i       ( pop       )
  );

  obi_txn_fifo i_txn_fifo (
    .clk_i,
    .rst_i,
    .push_i     ( push       ),
    .push_tgt_i ( push_tgt   ),
    .pop_i      ( pop        ),
    .head_tgt_o ( head_tgt   ),
    .empty_o    ( fifo_empty ),
    .full_o     ( fifo_full  )
  );

  // ----------------------------
  // Targets
  // ----------------------------
  for (genvar i = 0; i < `NUM_SRAM_BANKS; i++) begin : gen_sram_bank
    obi_sram_bank i_sram_bank (
      .clk_i,
      .rst_i,
      .obi_req_i ( tgt_req[i] ),
      .obi_rsp_o ( tgt_rsp[i] )
    );
  end

  obi_err_sbr i_err_sbr (
    .clk_i,
    .rst_i,
    .obi_req_i ( tgt_req[mem_map_pkg::TGT_ERROR] ),
    .obi_rsp_o ( tgt_rsp[mem_map_pkg::TGT_ERROR] )
  );

  // Response back to the manager
  obi_rsp_mux i_rsp_mux (
    .tgt_rsp_i  ( tgt_rsp    ),
    .head_tgt_i ( head_tgt   ),
    .empty_i    ( fifo_empty ),
    .rsp_o      ( mux_rsp    ),
    .pop_o      ( pop        )
  );

  assign obi_rsp_o.gnt    = gnt;
  assign obi_rsp_o.rvalid = mux_rsp.rvalid;
  assign obi_rsp_o.r      = mux_rsp.r;

endmodule

// File: obi_rsp_mux.sv
// ------------------------------
// OBI response mux
// Forwards the response owed by the FIFO head target
// ------------------------------
`include "mem_domain_params.svh"

module obi_rsp_mux (
  input  obi_pkg::obi_rsp_t [`NUM_TARGETS-1:0] tgt_rsp_i,
  input  mem_map_pkg::target_e                 head_tgt_i,
  input  logic                                 empty_i,
  output obi_pkg::obi_rsp_t                    rsp_o,
  output logic                                 pop_o
);

  localparam int unsigned N = `NUM_TARGETS;

  obi_pkg::obi_rsp_t head_rsp;
  logic [N-1:0]      rvalid_vec;

  assign head_rsp = tgt_rsp_i[head_tgt_i];
  assign pop_o    = !empty_i && head_rsp.rvalid;

  // Grant is merged in by the top
  assign rsp_o.gnt    = 1'b0;
  assign rsp_o.rvalid = pop_o;
  assign rsp_o.r      = head_rsp.r;

  // Responses must come back in issue order
  always_comb begin
    for (int unsigned t = 0; t < N; t++) begin
      rvalid_vec[t] = tgt_rsp_i[t].rvalid;
    end
    if (|rvalid_vec) begin
      assert final (!empty_i && (rvalid_vec == (N'(1) << head_tgt_i)))
        else $error("rsp mux: rvalid from a target that is not at the head");
    end
  end

endmodule

// File: obi_err_sbr.sv
// ------------------------------
// OBI bus-error subordinate
// Answers unmapped accesses with err and a fixed word
// ------------------------------
`include "mem_domain_params.svh"

module obi_err_sbr (
  input  logic              clk_i,
  input  logic              rst_i,
  input  obi_pkg::obi_req_t obi_req_i,
  output obi_pkg::obi_rsp_t obi_rsp_o
);

  localparam int unsigned LAT = `RSP_LATENCY;

  // One bit per pipeline stage
  logic [LAT-1:0] vld_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= (vld_q << 1) | LAT'(obi_req_i.req);
    end
  end

  // Same answer for reads and writes
  assign obi_rsp_o.gnt     = 1'b1;
  assign obi_rsp_o.rvalid  = vld_q[LAT-1];
  assign obi_rsp_o.r.rdata = `ERR_RSP_DATA;
  assign obi_rsp_o.r.err   = 1'b1;

endmodule

// File: obi_sram_bank.sv
// ------------------------------
// OBI SRAM bank
// Word memory with byte enables, fixed read latency
// ------------------------------
`include "mem_domain_params.svh"

module obi_sram_bank (
  input  logic              clk_i,
  input  logic              rst_i,
  input  obi_pkg::obi_req_t obi_req_i,
  output obi_pkg::obi_rsp_t obi_rsp_o
);

  localparam int unsigned WORD_AW   = $clog2(`SRAM_BANK_WORDS);
  localparam int unsigned NUM_BYTES = `OBI_DATA_WIDTH / 8;
  localparam int unsigned LAT       = `RSP_LATENCY;

  obi_pkg::data_t     mem_q [`SRAM_BANK_WORDS];
  logic [WORD_AW-1:0] word_addr;
  logic [LAT-1:0]     vld_q;
  obi_pkg::data_t     rdata_q [LAT];

  // Byte address to word index inside the bank
  assign word_addr = obi_req_i.a.addr[WORD_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req && obi_req_i.a.we) begin
      for (int unsigned b = 0; b < NUM_BYTES; b++) begin
        if (obi_req_i.a.be[b]) begin
          mem_q[word_addr][8*b +: 8] <= obi_req_i.a.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data pipeline, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q[0] <= obi_req_i.a.we ? '0 : mem_q[word_addr];
    end
    for (int unsigned s = 1; s < LAT; s++) begin
      rdata_q[s] <= rdata_q[s-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= (vld_q << 1) | LAT'(obi_req_i.req);
    end
  end

  // Always ready
  assign obi_rsp_o.gnt     = 1'b1;
  assign obi_rsp_o.rvalid  = vld_q[LAT-1];
  assign obi_rsp_o.r.rdata = rdata_q[LAT-1];
  assign obi_rsp_o.r.err   = 1'b0;

endmodule

// File: obi_txn_fifo.sv
// ------------------------------
// Transaction order FIFO
// Target index of each in-flight transaction, oldest first
// ------------------------------
`include "mem_domain_params.svh"

module obi_txn_fifo (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 push_i,
  input  mem_map_pkg::target_e push_tgt_i,
  input  logic                 pop_i,
  output mem_map_pkg::target_e head_tgt_o,
  output logic                 empty_o,
  output logic                 full_o
);

  localparam int unsigned DEPTH = `MAX_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mem_map_pkg::target_e slot_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 do_push;
  logic                 do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CNT_W'(DEPTH));
  // A full FIFO still takes a push when the head leaves this cycle
  assign do_push    = push_i && (!full_o || pop_i);
  assign do_pop     = pop_i && !empty_o;
  assign head_tgt_o = slot_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      slot_q[wr_ptr_q] <= push_tgt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------
  // Checks
  // ----------------------------
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (!full_o || pop_i))
    else $error("txn fifo: push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o)
    else $error("txn fifo: pop while empty");

endmodule

// File: obi_addr_demux.sv
// ------------------------------
// OBI address demux
// Steers each request to one bank or the error target
// ------------------------------
`include "mem_domain_params.svh"

module obi_addr_demux (
  input  obi_pkg::obi_req_t                     obi_req_i,
  output logic                                  gnt_o,
  output obi_pkg::obi_req_t [`NUM_TARGETS-1:0]  tgt_req_o,
  output logic                                  push_o,
  output mem_map_pkg::target_e                  push_tgt_o,
  input  logic                                  fifo_full_i,
  input  logic                                  pop_i
);

  mem_map_pkg::target_e    dec_tgt;
  logic                    accept;
  logic [`NUM_TARGETS-1:0] tgt_req;

  // Anything outside the bank window goes to the error target
  always_comb begin
    dec_tgt = mem_map_pkg::TGT_ERROR;
    for (int unsigned b = 0; b < `NUM_SRAM_BANKS; b++) begin
      if ((obi_req_i.a.addr >= obi_pkg::addr_t'(`SRAM_BASE_ADDR + b * `SRAM_BANK_BYTES)) &&
          (obi_req_i.a.addr < obi_pkg::addr_t'(`SRAM_BASE_ADDR + (b + 1) * `SRAM_BANK_BYTES)))
      begin
        dec_tgt = mem_map_pkg::target_e'(b);
      end
    end
  end

  // Hold off only when the order FIFO has no room this cycle
  assign gnt_o      = !fifo_full_i || pop_i;
  assign accept     = obi_req_i.req && gnt_o;
  assign push_o     = accept;
  assign push_tgt_o = dec_tgt;

  // Fields go to every target but req only to the decoded one
  always_comb begin
    for (int unsigned t = 0; t < `NUM_TARGETS; t++) begin
      tgt_req[t]       = accept && (dec_tgt == mem_map_pkg::target_e'(t));
      tgt_req_o[t].req = tgt_req[t];
      tgt_req_o[t].a   = obi_req_i.a;
    end
  end

endmodule

// File: mem_map_pkg.sv
// ------------------------------
// Memory map targets
// ------------------------------

package mem_map_pkg;

  // Index of the subordinate that owns an address
  // Banks come first so bank n has index n
  typedef enum logic [1:0] {
    TGT_BANK0 = 2'd0,
    TGT_BANK1 = 2'd1,
    TGT_ERROR = 2'd2
  } target_e;

endpackage

// File: obi_pkg.sv
// ------------------------------
// OBI bus types
// Request and response channels of the memory domain
// ------------------------------
`include "mem_domain_params.svh"

package obi_pkg;

  typedef logic [`OBI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`OBI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`OBI_DATA_WIDTH/8-1:0] be_t;

  // Request channel, valid while req is high
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } obi_a_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  // Response channel, valid while rvalid is high
  typedef struct packed {
    data_t rdata;
    logic  err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

endpackage

// File: mem_domain_params.svh
// ------------------------------
// Memory domain parameters
// Widths, address map and timing of the bus side
// ------------------------------
`ifndef MEM_DOMAIN_PARAMS_SVH
`define MEM_DOMAIN_PARAMS_SVH

// Bus widths
`define OBI_ADDR_WIDTH 32
`define OBI_DATA_WIDTH 32

// Address map, banks are contiguous from the base
`define NUM_SRAM_BANKS 2
`define NUM_TARGETS (`NUM_SRAM_BANKS + 1)
`define SRAM_BANK_WORDS 256
`define SRAM_BANK_BYTES (`SRAM_BANK_WORDS * (`OBI_DATA_WIDTH / 8))
`define SRAM_BASE_ADDR 32'h1000_0000

// Answer of the bus-error subordinate
`define ERR_RSP_DATA 32'hBADCAB1E

// Grant to rvalid, same for every target
`define RSP_LATENCY 2
// Outstanding transactions
`define MAX_TRANS 2

`endif
